// File: kbd_pkg.sv
package kbd_pkg;

   typedef logic [6:0]  key_code_t;
   typedef logic [3:0]  shift_state_t;
   typedef logic [10:0] key_event_t;   // Shift state on top of the key code

   typedef logic [31:0] wb_data_t;
   typedef logic [2:0]  wb_adr_t;      // Word address
   typedef logic [3:0]  wb_sel_t;

   // Queue size and the fixed model number reported in the status word
   localparam int queue_depth = 8;
   localparam logic [2:0] kbd_model = 3'd0;

   localparam wb_adr_t adr_event   = 3'd0;  // Status word and oldest event
   localparam wb_adr_t adr_control = 3'd1;

   // Field positions in the status word
   localparam int stat_valid_bit    = 31;
   localparam int stat_model_msb    = 30;
   localparam int stat_model_lsb    = 28;
   localparam int stat_shift_msb    = 27;
   localparam int stat_shift_lsb    = 24;
   localparam int stat_overflow_bit = 23;
   localparam int stat_key_msb      = 22;
   localparam int stat_key_lsb      = 16;

   // The keyboard_block bit lives in the top byte of the control word
   localparam int ctrl_block_bit  = 24;
   localparam int ctrl_block_lane = 3;

endpackage

// File: kbd_queue_if.sv
`timescale 1ns/1ps

interface kbd_queue_if;
   import kbd_pkg::*;

   logic       pop;       // One-cycle request to drop the head entry
   logic       valid;     // Head entry holds an event
   key_event_t head;
   logic       overflow;  // Sticky until the next pop

   modport queue (
      input  pop,
      output valid,
      output head,
      output overflow
   );

   modport regs (
      output pop,
      input  valid,
      input  head,
      input  overflow
   );

endinterface

// File: kbd_event_queue.sv
`timescale 1ns/1ps

module kbd_event_queue (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  keypress,
   input  kbd_pkg::key_code_t    keycode,
   input  kbd_pkg::shift_state_t shift_state,
   kbd_queue_if.queue            q
);
   import kbd_pkg::*;

   key_event_t             entry_data [queue_depth];
   key_event_t             shift_in   [queue_depth];
   key_event_t             new_event;
   logic [queue_depth-1:0] inuse;
   logic [queue_depth-1:0] prev_used;
   logic [queue_depth-1:0] near_used;
   logic [queue_depth-1:0] load;
   logic                   do_pop;
   logic                   full;
   logic                   overflow;

   assign new_event = {shift_state, keycode};
   assign full      = &inuse;
   assign do_pop    = q.pop & inuse[queue_depth-1];  // Pop of an empty queue does nothing

   // Neighbour state on the tail side and on the head side of each entry
   assign prev_used = {inuse[queue_depth-2:0], 1'b0};
   assign near_used = {1'b1, inuse[queue_depth-1:1]};

   // Entry i takes the value of entry i-1 on a pop
   always_comb begin
      shift_in[0] = new_event;
      for (int i = 1; i < queue_depth; i++) begin
         shift_in[i] = entry_data[i-1];
      end
   end

   // Used entries always form one run that ends at the head.
   // A push goes just behind that run, or just behind it after the shift on a pop.
   always_comb begin
      if (do_pop) begin
         load = {queue_depth{keypress}} & inuse & ~prev_used;
      end else begin
         load = {queue_depth{keypress}} & ~inuse & near_used;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < queue_depth; i++) begin
         if (load[i]) begin
            entry_data[i] <= new_event;
         end else if (do_pop) begin
            entry_data[i] <= shift_in[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         inuse    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_pop) begin
            inuse <= prev_used | load;
         end else begin
            inuse <= inuse | load;
         end

         if (do_pop) begin
            overflow <= 1'b0;
         end else if (keypress && full) begin
            overflow <= 1'b1;  // Event is lost
         end
      end
   end

   assign q.valid    = inuse[queue_depth-1];
   assign q.head     = entry_data[queue_depth-1];
   assign q.overflow = overflow;

endmodule

// File: kbd_wb_regs.sv
`timescale 1ns/1ps

module kbd_wb_regs (
   input  logic              clk,
   input  logic              reset,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  kbd_pkg::wb_adr_t  adr,
   input  kbd_pkg::wb_sel_t  sel,
   input  kbd_pkg::wb_data_t dat_w,
   output kbd_pkg::wb_data_t dat_r,
   output logic              ack,
   output logic              keyboard_block,
   kbd_queue_if.regs         q
);
   import kbd_pkg::*;

   logic         access;
   logic         read_event;
   logic         write_control;
   key_code_t    head_code;
   shift_state_t head_shift;
   wb_data_t     status_word;
   wb_data_t     control_word;
   wb_data_t     read_word;

   // A new access is one the slave has not acknowledged yet
   assign access = cyc & stb & ~ack;

   assign read_event    = access & ~we & (adr == adr_event);
   assign write_control = access & we & (adr == adr_control) & sel[ctrl_block_lane];

   // The head leaves the queue at the same edge that raises ack
   assign q.pop = read_event;

   assign {head_shift, head_code} = q.head;

   always_comb begin
      status_word = '0;
      status_word[stat_valid_bit] = q.valid;
      status_word[stat_model_msb:stat_model_lsb] = kbd_model;
      status_word[stat_overflow_bit] = q.overflow;
      if (q.valid) begin
         status_word[stat_shift_msb:stat_shift_lsb] = head_shift;
         status_word[stat_key_msb:stat_key_lsb]     = head_code;
      end
   end

   always_comb begin
      control_word = '0;
      control_word[ctrl_block_bit] = keyboard_block;
   end

   always_comb begin
      case (adr)
         adr_event:   read_word = status_word;
         adr_control: read_word = control_word;
         default:     read_word = '0;  // Unmapped addresses read as zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= access;  // Single-cycle ack that never repeats back to back
      end
   end

   always_ff @(posedge clk) begin
      if (access && !we) begin
         dat_r <= read_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         keyboard_block <= 1'b0;
      end else if (write_control) begin
         keyboard_block <= dat_w[ctrl_block_bit];
      end
   end

endmodule

// File: kbd_mmio_top.sv
`timescale 1ns/1ps

module kbd_mmio_top (
   input  logic                  clk,
   input  logic                  reset,

   // Wishbone classic slave
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  kbd_pkg::wb_adr_t      adr,
   input  kbd_pkg::wb_sel_t      sel,
   input  kbd_pkg::wb_data_t     dat_w,
   output kbd_pkg::wb_data_t     dat_r,
   output logic                  ack,

   // Key source
   input  logic                  keypress,
   input  kbd_pkg::key_code_t    keycode,
   input  kbd_pkg::shift_state_t shift_state,
   output logic                  keyboard_block
);

   kbd_queue_if q_if ();

   kbd_event_queue u_queue (
      .clk         (clk),
      .reset       (reset),
      .keypress    (keypress),
      .keycode     (keycode),
      .shift_state (shift_state),
      .q           (q_if.queue)
   );

   kbd_wb_regs u_regs (
      .clk            (clk),
      .reset          (reset),
      .cyc            (cyc),
      .stb            (stb),
      .we             (we),
      .adr            (adr),
      .sel            (sel),
      .dat_w          (dat_w),
      .dat_r          (dat_r),
      .ack            (ack),
      .keyboard_block (keyboard_block),
      .q              (q_if.regs)
   );

endmodule

// File: tb_kbd_mmio.sv
`timescale 1ns/1ps

module tb_kbd_mmio;
   import kbd_pkg::*;

   typedef enum logic [2:0] {
      op_press,
      op_read,
      op_write,
      op_idle,
      op_press_read
   } op_t;

   typedef struct packed {
      op_t          op;
      wb_adr_t      adr;
      wb_data_t     wdata;
      wb_sel_t      sel;
      key_code_t    code;
      shift_state_t shift;
      wb_data_t     exp_data;
      logic         exp_block;
   } step_t;

   logic         clk;
   logic         reset;
   logic         cyc;
   logic         stb;
   logic         we;
   wb_adr_t      adr;
   wb_sel_t      sel;
   wb_data_t     dat_w;
   wb_data_t     dat_r;
   logic         ack;
   logic         keypress;
   key_code_t    keycode;
   shift_state_t shift_state;
   logic         keyboard_block;

   step_t steps[$];
   int    cycles = 0;
   int    cycle_limit;

   kbd_mmio_top uut (
      .clk            (clk),
      .reset          (reset),
      .cyc            (cyc),
      .stb            (stb),
      .we             (we),
      .adr            (adr),
      .sel            (sel),
      .dat_w          (dat_w),
      .dat_r          (dat_r),
      .ack            (ack),
      .keypress       (keypress),
      .keycode        (keycode),
      .shift_state    (shift_state),
      .keyboard_block (keyboard_block)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("the test did not finish in time");
         $display("sim failed");
         $fatal(1);
      end
   end

   // Status word as laid out in the register map
   function automatic wb_data_t status(input logic valid, input logic ovf,
                                       input shift_state_t shift, input key_code_t code);
      wb_data_t w;
      w = '0;
      w[31] = valid;
      w[30:28] = kbd_model;
      w[23] = ovf;
      if (valid) begin
         w[27:24] = shift;
         w[22:16] = code;
      end
      return w;
   endfunction

   task automatic add_step(input op_t op, input wb_adr_t a, input wb_data_t d, input wb_sel_t s,
                           input key_code_t code, input shift_state_t sh,
                           input wb_data_t exp_d, input logic exp_b);
      step_t st;
      st.op = op;
      st.adr = a;
      st.wdata = d;
      st.sel = s;
      st.code = code;
      st.shift = sh;
      st.exp_data = exp_d;
      st.exp_block = exp_b;
      steps.push_back(st);
   endtask

   task automatic add_press(input key_code_t code, input shift_state_t sh, input logic blk);
      add_step(op_press, 3'd0, '0, 4'h0, code, sh, '0, blk);
   endtask

   task automatic add_read(input wb_adr_t a, input wb_data_t exp_d, input logic blk);
      add_step(op_read, a, '0, 4'hf, 7'h0, 4'h0, exp_d, blk);
   endtask

   task automatic add_write(input wb_adr_t a, input wb_data_t d, input wb_sel_t s, input logic blk);
      add_step(op_write, a, d, s, 7'h0, 4'h0, '0, blk);
   endtask

   task automatic build_table();
      add_read(3'd0, status(1'b0, 1'b0, 4'h0, 7'h0), 1'b0);  // Empty after reset
      add_read(3'd1, 32'h0, 1'b0);

      add_press(7'h1c, 4'h1, 1'b0);
      add_press(7'h2a, 4'h0, 1'b0);
      add_press(7'h41, 4'h5, 1'b0);
      add_read(3'd0, status(1'b1, 1'b0, 4'h1, 7'h1c), 1'b0);
      add_read(3'd0, status(1'b1, 1'b0, 4'h0, 7'h2a), 1'b0);
      add_read(3'd0, status(1'b1, 1'b0, 4'h5, 7'h41), 1'b0);
      add_read(3'd0, status(1'b0, 1'b0, 4'h0, 7'h0), 1'b0);

      // Two more presses than the queue holds
      for (int i = 0; i < queue_depth + 2; i++) begin
         add_press(7'h10 + 7'(i), 4'(i), 1'b0);
      end
      for (int i = 0; i < queue_depth; i++) begin
         add_read(3'd0, status(1'b1, i == 0, 4'(i), 7'h10 + 7'(i)), 1'b0);
      end
      add_read(3'd0, status(1'b0, 1'b0, 4'h0, 7'h0), 1'b0);

      for (int i = 0; i < queue_depth; i++) begin
         add_press(7'h30 + 7'(i), 4'(i + 2), 1'b0);
      end
      add_step(op_press_read, adr_event, '0, 4'hf, 7'h5a, 4'h9,
               status(1'b1, 1'b0, 4'h2, 7'h30), 1'b0);
      for (int i = 1; i < queue_depth; i++) begin
         add_read(3'd0, status(1'b1, 1'b0, 4'(i + 2), 7'h30 + 7'(i)), 1'b0);
      end
      add_read(3'd0, status(1'b1, 1'b0, 4'h9, 7'h5a), 1'b0);
      add_read(3'd0, status(1'b0, 1'b0, 4'h0, 7'h0), 1'b0);

      add_write(3'd1, 32'h0100_0000, 4'h8, 1'b1);
      add_read(3'd1, 32'h0100_0000, 1'b1);
      add_write(3'd1, 32'h0000_0000, 4'h7, 1'b1);  // Top lane not selected
      add_read(3'd1, 32'h0100_0000, 1'b1);
      add_write(3'd1, 32'h0000_0000, 4'hf, 1'b0);
      add_read(3'd1, 32'h0, 1'b0);

      add_press(7'h61, 4'h3, 1'b0);
      add_press(7'h62, 4'h4, 1'b0);
      add_step(op_idle, 3'd0, '0, 4'h0, 7'h0, 4'h0, '0, 1'b0);
      for (int a = 2; a < 8; a++) begin
         add_read(3'(a), 32'h0, 1'b0);
      end
      for (int a = 2; a < 8; a++) begin
         add_write(3'(a), 32'hffff_ffff, 4'hf, 1'b0);
      end
      add_read(3'd0, status(1'b1, 1'b0, 4'h3, 7'h61), 1'b0);
      add_read(3'd0, status(1'b1, 1'b0, 4'h4, 7'h62), 1'b0);
      add_read(3'd0, status(1'b0, 1'b0, 4'h0, 7'h0), 1'b0);
   endtask

   task automatic report_error(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic bus_access(input step_t st);
      cyc = 1'b1;
      stb = 1'b1;
      we = (st.op == op_write);
      adr = st.adr;
      sel = st.sel;
      dat_w = st.wdata;
      @(negedge clk);
      keypress = 1'b0;  // A press that shares the access lasts one cycle only
      while (ack !== 1'b1) begin
         @(negedge clk);
      end
      if (st.op != op_write) begin
         assert (dat_r === st.exp_data)
         else report_error($sformatf("read at adr %0d returned %h, expected %h",
                                     st.adr, dat_r, st.exp_data));
      end
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      @(negedge clk);
      assert (ack === 1'b0)
      else report_error("ack stayed high for more than one cycle");
   endtask

   task automatic apply_step(input step_t st);
      case (st.op)
         op_press: begin
            keypress = 1'b1;
            keycode = st.code;
            shift_state = st.shift;
            @(negedge clk);
            keypress = 1'b0;
         end
         op_press_read: begin
            keypress = 1'b1;
            keycode = st.code;
            shift_state = st.shift;
            bus_access(st);
         end
         op_idle: @(negedge clk);
         default: bus_access(st);
      endcase
      assert (keyboard_block === st.exp_block)
      else report_error($sformatf("keyboard_block is %b, expected %b",
                                  keyboard_block, st.exp_block));
   endtask

   initial begin
      reset = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      sel = '0;
      dat_w = '0;
      keypress = 1'b0;
      keycode = '0;
      shift_state = '0;
      build_table();
      cycle_limit = steps.size() * 4 + 100;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < steps.size(); i++) begin
         apply_step(steps[i]);
      end
      $display("sim passed");
      $finish;
   end

endmodule

// File: verilog.f
kbd_pkg.sv
kbd_queue_if.sv
kbd_event_queue.sv
kbd_wb_regs.sv
kbd_mmio_top.sv
tb_kbd_mmio.sv
